// ==== flist.f ====
src/shell_cfg_pkg.sv
src/shell_bus_pkg.sv
src/host_window.sv
src/mem_arbiter.sv
src/dram_remap.sv
src/usage_monitor.sv
src/shell_csr.sv
src/shell_top.sv
sim/tb_shell_top.sv

// ==== sim/tb_shell_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_shell_top
   import shell_cfg_pkg::*;
   import shell_bus_pkg::*;
   ();

   localparam int    N_REQ           = 28;
   localparam int    WATCHDOG_CYCLES = 200 * N_REQ + 1000;
   localparam data_t RD_PATTERN      = 32'h5a5a_0000;

   logic      clk_i;
   logic      rst_n_i;
   logic      host_req_i;
   host_req_t host_pkt_i;
   logic      host_ack_o;
   mem_rsp_t  host_rsp_o;
   logic      miss_req_i;
   mem_req_t  miss_pkt_i;
   logic      miss_ack_o;
   mem_rsp_t  miss_rsp_o;
   logic      dram_req_o;
   dram_req_t dram_pkt_o;
   logic      dram_ack_i;
   mem_rsp_t  dram_rsp_i;
   csr_req_t  csr_i;
   data_t     csr_rdata_o;
   logic      core_rst_n_o;

   int          errors;
   dram_req_t   exp_q [$];
   region_map_t exp_region;
   cnt_t        exp_cnt [2][2];
   dram_addr_t  cur_base;
   logic        dram_req_seen;
   int unsigned dram_dly;

   shell_top u_shell_top
     (.clk_i        (clk_i)
     ,.rst_n_i      (rst_n_i)
     ,.host_req_i   (host_req_i)
     ,.host_pkt_i   (host_pkt_i)
     ,.host_ack_o   (host_ack_o)
     ,.host_rsp_o   (host_rsp_o)
     ,.miss_req_i   (miss_req_i)
     ,.miss_pkt_i   (miss_pkt_i)
     ,.miss_ack_o   (miss_ack_o)
     ,.miss_rsp_o   (miss_rsp_o)
     ,.dram_req_o   (dram_req_o)
     ,.dram_pkt_o   (dram_pkt_o)
     ,.dram_ack_i   (dram_ack_i)
     ,.dram_rsp_i   (dram_rsp_i)
     ,.csr_i        (csr_i)
     ,.csr_rdata_o  (csr_rdata_o)
     ,.core_rst_n_o (core_rst_n_o)
     );

   always #2 clk_i = ~clk_i;

   // host window bit 29 is inverted, bit 28 is dropped
   function automatic core_addr_t ref_core_addr(input host_addr_t addr);
      return {~addr[29], 3'b000, addr[27:0]};
   endfunction

   function automatic dram_addr_t ref_dram_addr(input logic from_host, input core_addr_t addr,
                                                input dram_addr_t base);
      core_addr_t core;
      core = from_host ? ref_core_addr(addr[29:0]) : addr;
      return (core ^ 32'h8000_0000) + base;
   endfunction

   task automatic end_run();
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   endtask

   task automatic clear_expected();
      exp_region = '0;
      for (int c = 0; c < 2; c++)
         for (int w = 0; w < 2; w++)
            exp_cnt[c][w] = '0;
   endtask

   task automatic record_done(input int client, input logic we, input core_addr_t core);
      exp_region[core[27:23]] = 1'b1;
      exp_cnt[client][we] = exp_cnt[client][we] + 1;
   endtask

   task automatic host_access(input logic we, input host_addr_t addr, input data_t wdata);
      dram_req_t exp;
      exp.we    = we;
      exp.addr  = ref_dram_addr(1'b1, {2'b00, addr}, cur_base);
      exp.wdata = wdata;
      @(posedge clk_i);
      exp_q.push_back(exp);
      host_req_i       <= 1'b1;
      host_pkt_i.we    <= we;
      host_pkt_i.addr  <= addr;
      host_pkt_i.wdata <= wdata;
      do
         @(posedge clk_i);
      while (host_ack_o !== 1'b1);
      if (!we && host_rsp_o.rdata !== (exp.addr ^ RD_PATTERN))
      begin
         errors++;
         $display("mismatch at %0t: host_rsp_o got %h expected %h", $time,
                  host_rsp_o.rdata, exp.addr ^ RD_PATTERN);
      end
      host_req_i <= 1'b0;
      do
         @(posedge clk_i);
      while (host_ack_o !== 1'b0);
      record_done(0, we, ref_core_addr(addr));
   endtask

   task automatic miss_access(input logic we, input core_addr_t addr, input data_t wdata);
      dram_req_t exp;
      exp.we    = we;
      exp.addr  = ref_dram_addr(1'b0, addr, cur_base);
      exp.wdata = wdata;
      @(posedge clk_i);
      exp_q.push_back(exp);
      miss_req_i       <= 1'b1;
      miss_pkt_i.we    <= we;
      miss_pkt_i.addr  <= addr;
      miss_pkt_i.wdata <= wdata;
      do
         @(posedge clk_i);
      while (miss_ack_o !== 1'b1);
      if (!we && miss_rsp_o.rdata !== (exp.addr ^ RD_PATTERN))
      begin
         errors++;
         $display("mismatch at %0t: miss_rsp_o got %h expected %h", $time,
                  miss_rsp_o.rdata, exp.addr ^ RD_PATTERN);
      end
      miss_req_i <= 1'b0;
      do
         @(posedge clk_i);
      while (miss_ack_o !== 1'b0);
      record_done(1, we, addr);
   endtask

   task automatic csr_write(input csr_addr_t addr, input data_t wdata);
      @(posedge clk_i);
      csr_i.valid <= 1'b1;
      csr_i.we    <= 1'b1;
      csr_i.addr  <= addr;
      csr_i.wdata <= wdata;
      @(posedge clk_i);
      csr_i.valid <= 1'b0;
   endtask

   task automatic check_csr(input csr_addr_t addr, input data_t exp, input string name);
      @(posedge clk_i);
      csr_i.valid <= 1'b1;
      csr_i.we    <= 1'b0;
      csr_i.addr  <= addr;
      @(posedge clk_i);
      csr_i.valid <= 1'b0;
      @(posedge clk_i);
      if (csr_rdata_o !== exp)
      begin
         errors++;
         $display("mismatch at %0t: csr_rdata_o (%s) got %h expected %h", $time, name,
                  csr_rdata_o, exp);
      end
   endtask

   task automatic check_monitor();
      check_csr(CSR_REGION_MAP, exp_region, "CSR_REGION_MAP");
      check_csr(CSR_HOST_RD, exp_cnt[0][0], "CSR_HOST_RD");
      check_csr(CSR_HOST_WR, exp_cnt[0][1], "CSR_HOST_WR");
      check_csr(CSR_MISS_RD, exp_cnt[1][0], "CSR_MISS_RD");
      check_csr(CSR_MISS_WR, exp_cnt[1][1], "CSR_MISS_WR");
   endtask

   // DRAM model acks 1 to 4 cycles after it sees the request
   always @(posedge clk_i)
   begin
      if (dram_req_o && !dram_ack_i)
      begin
         if (dram_dly == 0)
         begin
            dram_ack_i       <= 1'b1;
            dram_rsp_i.rdata <= dram_pkt_o.addr ^ RD_PATTERN;
         end
         else
            dram_dly <= dram_dly - 1;
      end
      else if (!dram_req_o && dram_ack_i)
      begin
         dram_ack_i <= 1'b0;
         dram_dly   <= $urandom_range(3, 0);
      end
   end

   // every new DRAM request must match one outstanding expected request
   always @(posedge clk_i)
   begin : dram_checker
      int hit;
      hit = -1;
      if (dram_req_o && !dram_req_seen)
      begin
         for (int i = 0; i < exp_q.size(); i++)
            if (hit < 0 && exp_q[i] == dram_pkt_o)
               hit = i;
         if (hit >= 0)
            exp_q.delete(hit);
         else if (exp_q.size() == 0)
         begin
            errors++;
            $display("DRAM request at %0t with no request outstanding", $time);
         end
         else
         begin
            errors++;
            $display("mismatch at %0t: dram_pkt_o got %h expected %h", $time,
                     dram_pkt_o, exp_q[0]);
         end
      end
      dram_req_seen = dram_req_o;
   end

   always @(posedge clk_i)
   begin
      if (!core_rst_n_o && (host_ack_o || miss_ack_o || dram_req_o))
      begin
         errors++;
         $display("handshake active at %0t while the core is held in reset", $time);
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      errors++;
      end_run();
   end

   initial
   begin : stimulus
      int unsigned seed_val;
      host_addr_t  ha;
      core_addr_t  ca;
      seed_val      = $urandom(32'h6a0e);
      clk_i         = 1'b0;
      rst_n_i       = 1'b0;
      host_req_i    = 1'b0;
      host_pkt_i    = '0;
      miss_req_i    = 1'b0;
      miss_pkt_i    = '0;
      dram_ack_i    = 1'b0;
      dram_rsp_i    = '0;
      csr_i         = '0;
      errors        = 0;
      clear_expected();
      cur_base      = '0;
      dram_req_seen = 1'b0;
      dram_dly      = $urandom_range(3, 0);
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);
      if (core_rst_n_o !== 1'b0)
      begin
         errors++;
         $display("core reset released at %0t before CSR_CTRL was written", $time);
      end

      // requests while the core is held in reset must get no response
      host_req_i <= 1'b1;
      miss_req_i <= 1'b1;
      repeat (6) @(posedge clk_i);
      host_req_i <= 1'b0;
      miss_req_i <= 1'b0;
      repeat (2) @(posedge clk_i);

      cur_base = 32'h1234_0000;
      csr_write(CSR_DRAM_BASE, cur_base);
      csr_write(CSR_CTRL, 32'd1);
      @(posedge clk_i);
      if (core_rst_n_o !== 1'b1)
      begin
         errors++;
         $display("core reset still active at %0t after CSR_CTRL was set", $time);
      end

      // host traffic, alternating read and write, both windows
      for (int i = 0; i < 8; i++)
      begin
         ha = host_addr_t'($urandom);
         ha[29] = i[1];
         host_access(i[0], ha, $urandom);
      end

      for (int i = 0; i < 6; i++)
      begin
         ca = $urandom | 32'h8000_0000;
         miss_access(i[0], ca, $urandom);
      end

      // host and miss requests racing for the bus
      // a skew of one cycle on the miss side makes both reach the arbiter together
      for (int i = 0; i < 6; i++)
      begin
         ha = host_addr_t'($urandom);
         ca = $urandom | 32'h8000_0000;
         fork
            host_access(i[0], ha, $urandom);
            begin
               repeat (i[0] ? 1 : (i[1] ? 2 : 0)) @(posedge clk_i);
               miss_access(~i[0], ca, $urandom);
            end
         join
      end
      check_monitor();

      // a core reset cycle clears the monitor but not the base register
      csr_write(CSR_CTRL, 32'd0);
      csr_write(CSR_CTRL, 32'd1);
      clear_expected();
      check_monitor();
      check_csr(CSR_DRAM_BASE, cur_base, "CSR_DRAM_BASE");

      cur_base = 32'h0040_0000;
      csr_write(CSR_DRAM_BASE, cur_base);
      host_access(1'b0, 30'h2150_0a04, 32'h0);
      miss_access(1'b1, 32'h8f80_0010, 32'hcafe_0001);
      check_monitor();

      repeat (4) @(posedge clk_i);
      if (exp_q.size() != 0)
      begin
         errors++;
         $display("%0d requests never reached the DRAM port", exp_q.size());
      end
      end_run();
   end

endmodule

`default_nettype wire

// ==== src/dram_remap.sv ====
`timescale 1ns/10ps
`default_nettype none

module dram_remap
   import shell_cfg_pkg::*;
   import shell_bus_pkg::*;
   (
    input  logic       clk_i
   ,input  logic       rst_n_i
   ,input  logic       req_i
   ,input  mem_req_t   pkt_i
   ,output logic       ack_o
   ,output mem_rsp_t   rsp_o
   ,input  dram_addr_t dram_base_i
   ,output logic       dram_req_o
   ,output dram_req_t  dram_pkt_o
   ,input  logic       dram_ack_i
   ,input  mem_rsp_t   dram_rsp_i
   );

   logic       req_q;
   dram_req_t  pkt_q;
   dram_addr_t remap_addr;

   // strip the core DRAM base and move into the buffer the host allocated
   assign remap_addr = (pkt_i.addr ^ CORE_DRAM_BASE) + dram_base_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         req_q <= 1'b0;
      else
         req_q <= req_i;
   end

   // capture once on the rising request so a base change mid-transfer does no harm
   always_ff @(posedge clk_i)
   begin
      if (req_i && !req_q)
      begin
         pkt_q.we    <= pkt_i.we;
         pkt_q.addr  <= remap_addr;
         pkt_q.wdata <= pkt_i.wdata;
      end
   end

   assign dram_req_o = req_q;
   assign dram_pkt_o = pkt_q;
   assign ack_o      = dram_ack_i;
   assign rsp_o      = dram_rsp_i;

endmodule

`default_nettype wire

// ==== src/host_window.sv ====
`timescale 1ns/10ps
`default_nettype none

module host_window
   import shell_cfg_pkg::*;
   import shell_bus_pkg::*;
   (
    input  logic      clk_i
   ,input  logic      rst_n_i
   ,input  logic      host_req_i
   ,input  host_req_t host_pkt_i
   ,output logic      host_ack_o
   ,output mem_rsp_t  host_rsp_o
   ,output logic      bus_req_o
   ,output mem_req_t  bus_pkt_o
   ,input  logic      bus_ack_i
   ,input  mem_rsp_t  bus_rsp_i
   );

   typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_ACK, ST_REL} state_e;

   state_e     state_q;
   mem_req_t   pkt_q;
   mem_rsp_t   rsp_q;
   core_addr_t core_addr;

   // host 0x0xxx_xxxx lands in core DRAM at 0x8xxx_xxxx, host 0x2xxx_xxxx lands at 0x0xxx_xxxx
   assign core_addr = {~host_pkt_i.addr[WINDOW_SEL_BIT], 3'b000, host_pkt_i.addr[27:0]};

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= ST_IDLE;
      end
      else
      begin
         case (state_q)
            ST_IDLE: if (host_req_i) state_q <= ST_REQ;
            ST_REQ:  if (bus_ack_i) state_q <= ST_ACK;
            // the bus request is already down here, so the arbiter can drain
            ST_ACK:  if (!host_req_i) state_q <= ST_REL;
            ST_REL:  if (!bus_ack_i) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (state_q == ST_IDLE && host_req_i)
      begin
         pkt_q.we    <= host_pkt_i.we;
         pkt_q.addr  <= core_addr;
         pkt_q.wdata <= host_pkt_i.wdata;
      end
      if (state_q == ST_REQ && bus_ack_i)
         rsp_q <= bus_rsp_i;
   end

   assign bus_req_o  = (state_q == ST_REQ);
   assign bus_pkt_o  = pkt_q;
   assign host_ack_o = (state_q == ST_ACK);
   assign host_rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
   import shell_cfg_pkg::*;
   import shell_bus_pkg::*;
   (
    input  logic                             clk_i
   ,input  logic                             rst_n_i
   ,input  logic [NUM_CLIENTS-1:0]           cl_req_i
   ,input  mem_req_t [NUM_CLIENTS-1:0]       cl_pkt_i
   ,output logic [NUM_CLIENTS-1:0]           cl_ack_o
   ,output mem_rsp_t                         cl_rsp_o
   ,output logic                             dn_req_o
   ,output mem_req_t                         dn_pkt_o
   ,input  logic                             dn_ack_i
   ,input  mem_rsp_t                         dn_rsp_i
   ,output grant_evt_t                       grant_o
   );

   typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_DRAIN} state_e;

   state_e  state_q;
   client_t grant_q;
   client_t last_q;
   client_t winner;
   logic    ack_q;

   // when both clients want the bus, the one not served last time goes first
   always_comb
   begin
      if (cl_req_i[CLIENT_HOST] && cl_req_i[CLIENT_MISS])
         winner = ~last_q;
      else if (cl_req_i[CLIENT_MISS])
         winner = CLIENT_MISS;
      else
         winner = CLIENT_HOST;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= ST_IDLE;
         grant_q <= CLIENT_HOST;
         last_q  <= CLIENT_MISS;
         ack_q   <= 1'b0;
      end
      else
      begin
         ack_q <= dn_ack_i;
         case (state_q)
            ST_IDLE:
            begin
               if (|cl_req_i)
               begin
                  grant_q <= winner;
                  last_q  <= winner;
                  state_q <= ST_BUSY;
               end
            end
            // hold the downstream request until the winner lets go of its own
            ST_BUSY:  if (!cl_req_i[grant_q]) state_q <= ST_DRAIN;
            ST_DRAIN: if (!dn_ack_i) state_q <= ST_IDLE;
            default:  state_q <= ST_IDLE;
         endcase
      end
   end

   always_comb
   begin
      cl_ack_o = '0;
      if (state_q != ST_IDLE)
         cl_ack_o[grant_q] = dn_ack_i;
   end

   assign cl_rsp_o = dn_rsp_i;
   assign dn_req_o = (state_q == ST_BUSY);
   assign dn_pkt_o = cl_pkt_i[grant_q];

   // ack never stays high across transactions, so its rising edge marks each one once
   always_comb
   begin
      grant_o.valid  = (state_q == ST_BUSY) && dn_ack_i && !ack_q;
      grant_o.client = grant_q;
      grant_o.we     = cl_pkt_i[grant_q].we;
      grant_o.addr   = cl_pkt_i[grant_q].addr;
   end

endmodule

`default_nettype wire

// ==== src/shell_bus_pkg.sv ====
`default_nettype none

package shell_bus_pkg;
   import shell_cfg_pkg::*;

   // request in the core's address space
   typedef struct packed {
      logic       we;
      core_addr_t addr;
      data_t      wdata;
   } mem_req_t;

   // same request after remapping into host DRAM
   typedef struct packed {
      logic       we;
      dram_addr_t addr;
      data_t      wdata;
   } dram_req_t;

   typedef struct packed {
      logic       we;
      host_addr_t addr;
      data_t      wdata;
   } host_req_t;

   typedef struct packed {
      data_t rdata;
   } mem_rsp_t;

   // one-cycle pulse per transaction served by the arbiter
   typedef struct packed {
      logic       valid;
      client_t    client;
      logic       we;
      core_addr_t addr;
   } grant_evt_t;

   typedef struct packed {
      logic      valid;
      logic      we;
      csr_addr_t addr;
      data_t     wdata;
   } csr_req_t;

endpackage

`default_nettype wire

// ==== src/shell_cfg_pkg.sv ====
`default_nettype none

package shell_cfg_pkg;

   typedef logic [29:0] host_addr_t;
   typedef logic [31:0] core_addr_t;
   typedef logic [31:0] dram_addr_t;
   typedef logic [31:0] data_t;
   typedef logic [31:0] cnt_t;
   typedef logic [2:0]  csr_addr_t;
   typedef logic [31:0] region_map_t;
   typedef logic [0:0]  client_t;

   // host window select bit, inverted to pick core DRAM or core local space
   localparam int WINDOW_SEL_BIT = 29;
   localparam core_addr_t CORE_DRAM_BASE = 32'h8000_0000;

   // five index bits starting at bit 23 give 8 MB regions
   localparam int REGION_LSB = 23;
   localparam int REGION_W   = 5;

   localparam csr_addr_t CSR_CTRL       = 3'd0;
   localparam csr_addr_t CSR_DRAM_BASE  = 3'd1;
   localparam csr_addr_t CSR_REGION_MAP = 3'd2;
   localparam csr_addr_t CSR_HOST_RD    = 3'd3;
   localparam csr_addr_t CSR_HOST_WR    = 3'd4;
   localparam csr_addr_t CSR_MISS_RD    = 3'd5;
   localparam csr_addr_t CSR_MISS_WR    = 3'd6;

   localparam int      NUM_CLIENTS = 2;
   localparam client_t CLIENT_HOST = 1'b0;
   localparam client_t CLIENT_MISS = 1'b1;

endpackage

`default_nettype wire

// ==== src/shell_csr.sv ====
`timescale 1ns/10ps
`default_nettype none

module shell_csr
   import shell_cfg_pkg::*;
   import shell_bus_pkg::*;
   (
    input  logic        clk_i
   ,input  logic        rst_n_i
   ,input  csr_req_t    csr_i
   ,output data_t       csr_rdata_o
   ,output logic        core_rst_n_o
   ,output dram_addr_t  dram_base_o
   ,input  region_map_t region_map_i
   ,input  cnt_t        host_rd_i
   ,input  cnt_t        host_wr_i
   ,input  cnt_t        miss_rd_i
   ,input  cnt_t        miss_wr_i
   );

   logic       ctrl_q;
   dram_addr_t dram_base_q;
   data_t      rd_mux;
   data_t      rdata_q;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ctrl_q      <= 1'b0;
         dram_base_q <= '0;
      end
      else if (csr_i.valid && csr_i.we)
      begin
         case (csr_i.addr)
            CSR_CTRL:      ctrl_q <= csr_i.wdata[0];
            CSR_DRAM_BASE: dram_base_q <= csr_i.wdata;
            default:       ;
         endcase
      end
   end

   always_comb
   begin
      case (csr_i.addr)
         CSR_CTRL:       rd_mux = {31'b0, ctrl_q};
         CSR_DRAM_BASE:  rd_mux = dram_base_q;
         CSR_REGION_MAP: rd_mux = region_map_i;
         CSR_HOST_RD:    rd_mux = host_rd_i;
         CSR_HOST_WR:    rd_mux = host_wr_i;
         CSR_MISS_RD:    rd_mux = miss_rd_i;
         CSR_MISS_WR:    rd_mux = miss_wr_i;
         default:        rd_mux = '0;
      endcase
   end

   // read data shows up the cycle after the read and then holds
   always_ff @(posedge clk_i)
   begin
      if (csr_i.valid && !csr_i.we)
         rdata_q <= rd_mux;
   end

   // the core side stays in reset until the host sets the control bit
   assign core_rst_n_o = rst_n_i & ctrl_q;
   assign dram_base_o  = dram_base_q;
   assign csr_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== src/shell_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module shell_top
   import shell_cfg_pkg::*;
   import shell_bus_pkg::*;
   (
    input  logic      clk_i
   ,input  logic      rst_n_i
   ,input  logic      host_req_i
   ,input  host_req_t host_pkt_i
   ,output logic      host_ack_o
   ,output mem_rsp_t  host_rsp_o
   ,input  logic      miss_req_i
   ,input  mem_req_t  miss_pkt_i
   ,output logic      miss_ack_o
   ,output mem_rsp_t  miss_rsp_o
   ,output logic      dram_req_o
   ,output dram_req_t dram_pkt_o
   ,input  logic      dram_ack_i
   ,input  mem_rsp_t  dram_rsp_i
   ,input  csr_req_t  csr_i
   ,output data_t     csr_rdata_o
   ,output logic      core_rst_n_o
   );

   logic                       core_rst_n;
   logic                       win_req, win_ack;
   mem_req_t                   win_pkt;
   logic [NUM_CLIENTS-1:0]     cl_req, cl_ack;
   mem_req_t [NUM_CLIENTS-1:0] cl_pkt;
   mem_rsp_t                   cl_rsp;
   logic                       arb_req, arb_ack;
   mem_req_t                   arb_pkt;
   mem_rsp_t                   arb_rsp;
   grant_evt_t                 grant;
   dram_addr_t                 dram_base;
   region_map_t                region_map;
   cnt_t                       host_rd, host_wr, miss_rd, miss_wr;

   // the cache-miss port is already in core addresses and goes straight to the arbiter
   assign cl_req[CLIENT_HOST] = win_req;
   assign cl_pkt[CLIENT_HOST] = win_pkt;
   assign cl_req[CLIENT_MISS] = miss_req_i;
   assign cl_pkt[CLIENT_MISS] = miss_pkt_i;
   assign win_ack             = cl_ack[CLIENT_HOST];
   assign miss_ack_o          = cl_ack[CLIENT_MISS];
   assign miss_rsp_o          = cl_rsp;
   assign core_rst_n_o        = core_rst_n;

   host_window u_host_window
     (.clk_i      (clk_i)
     ,.rst_n_i    (core_rst_n)
     ,.host_req_i (host_req_i)
     ,.host_pkt_i (host_pkt_i)
     ,.host_ack_o (host_ack_o)
     ,.host_rsp_o (host_rsp_o)
     ,.bus_req_o  (win_req)
     ,.bus_pkt_o  (win_pkt)
     ,.bus_ack_i  (win_ack)
     ,.bus_rsp_i  (cl_rsp)
     );

   mem_arbiter u_mem_arbiter
     (.clk_i    (clk_i)
     ,.rst_n_i  (core_rst_n)
     ,.cl_req_i (cl_req)
     ,.cl_pkt_i (cl_pkt)
     ,.cl_ack_o (cl_ack)
     ,.cl_rsp_o (cl_rsp)
     ,.dn_req_o (arb_req)
     ,.dn_pkt_o (arb_pkt)
     ,.dn_ack_i (arb_ack)
     ,.dn_rsp_i (arb_rsp)
     ,.grant_o  (grant)
     );

   dram_remap u_dram_remap
     (.clk_i       (clk_i)
     ,.rst_n_i     (core_rst_n)
     ,.req_i       (arb_req)
     ,.pkt_i       (arb_pkt)
     ,.ack_o       (arb_ack)
     ,.rsp_o       (arb_rsp)
     ,.dram_base_i (dram_base)
     ,.dram_req_o  (dram_req_o)
     ,.dram_pkt_o  (dram_pkt_o)
     ,.dram_ack_i  (dram_ack_i)
     ,.dram_rsp_i  (dram_rsp_i)
     );

   usage_monitor u_usage_monitor
     (.clk_i        (clk_i)
     ,.rst_n_i      (core_rst_n)
     ,.grant_i      (grant)
     ,.region_map_o (region_map)
     ,.host_rd_o    (host_rd)
     ,.host_wr_o    (host_wr)
     ,.miss_rd_o    (miss_rd)
     ,.miss_wr_o    (miss_wr)
     );

   // the register file alone runs on the external reset so the base survives a core reset
   shell_csr u_shell_csr
     (.clk_i        (clk_i)
     ,.rst_n_i      (rst_n_i)
     ,.csr_i        (csr_i)
     ,.csr_rdata_o  (csr_rdata_o)
     ,.core_rst_n_o (core_rst_n)
     ,.dram_base_o  (dram_base)
     ,.region_map_i (region_map)
     ,.host_rd_i    (host_rd)
     ,.host_wr_i    (host_wr)
     ,.miss_rd_i    (miss_rd)
     ,.miss_wr_i    (miss_wr)
     );

endmodule

`default_nettype wire

// ==== src/usage_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module usage_monitor
   import shell_cfg_pkg::*;
   import shell_bus_pkg::*;
   (
    input  logic        clk_i
   ,input  logic        rst_n_i
   ,input  grant_evt_t  grant_i
   ,output region_map_t region_map_o
   ,output cnt_t        host_rd_o
   ,output cnt_t        host_wr_o
   ,output cnt_t        miss_rd_o
   ,output cnt_t        miss_wr_o
   );

   region_map_t region_q;
   cnt_t        cnt_q [4];
   logic [1:0]  cnt_idx;

   // counters ordered host read, host write, miss read, miss write
   assign cnt_idx = {grant_i.client, grant_i.we};

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         region_q <= '0;
         for (int i = 0; i < 4; i++)
            cnt_q[i] <= '0;
      end
      else if (grant_i.valid)
      begin
         region_q[grant_i.addr[REGION_LSB +: REGION_W]] <= 1'b1;
         cnt_q[cnt_idx] <= cnt_q[cnt_idx] + 1'b1;
      end
   end

   assign region_map_o = region_q;
   assign host_rd_o    = cnt_q[0];
   assign host_wr_o    = cnt_q[1];
   assign miss_rd_o    = cnt_q[2];
   assign miss_wr_o    = cnt_q[3];

endmodule

`default_nettype wire
